// File: verilog/qupls_fetch_pkg.sv
// Fetch alignment package with opcodes, buffer sizes and the reset address
`default_nettype none

package qupls_fetch_pkg;

	// ====================
	// Opcodes
	// ====================

	// The opcode sits in the low seven bits of an instruction's first byte
	typedef enum logic [6:0] {
		OP_CSR    = 7'd7,
		OP_FLT3   = 7'd12,
		OP_BSR    = 7'd32,
		OP_JSR    = 7'd33,
		OP_Bcc    = 7'd40,
		OP_BccU   = 7'd41,
		OP_PFXA32 = 7'd48,
		OP_PFXB32 = 7'd49,
		OP_PFXC32 = 7'd50,
		OP_PFXA64 = 7'd52,
		OP_PFXB64 = 7'd53,
		OP_PFXC64 = 7'd54,
		OP_RTS    = 7'd58,
		OP_VEC    = 7'd100,
		OP_NOP    = 7'd127
	} opcode_t;

	// ====================
	// Sizes
	// ====================

	// Bytes delivered by one fetch line
	localparam int LINE_BYTES = 8;
	// Byte capacity of the line buffer, three fetch lines
	localparam int BUF_BYTES = 24;
	// Longest instruction, a 64-bit constant prefix
	localparam int MAX_INS_BYTES = 10;
	// Width of a length or of a byte count in the buffer
	localparam int LEN_W = 5;
	// Entries in the output queue
	localparam int QUEUE_DEPTH = 2;
	// Queue pointer and occupancy widths
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	// Address of the first instruction after reset
	localparam logic [31:0] RESET_PC = 32'hFFFD_0000;

endpackage

`default_nettype wire

// File: verilog/qupls_fetch_if.sv
// Interfaces between the line buffer, the aligner and the output queue
`timescale 1ns/1ps
`default_nettype none

// Buffer contents seen by the aligner, and the aligner's consume request
interface fetch_buf_if;
	import qupls_fetch_pkg::*;
	logic [BUF_BYTES-1:0][7:0] buf_bytes;
	logic [LEN_W-1:0] count;
	logic [31:0] head_pc;
	logic take;
	logic [LEN_W-1:0] take_len;
	modport producer (output buf_bytes, count, head_pc, input take, take_len);
	modport consumer (input buf_bytes, count, head_pc, output take, take_len);
endinterface

// One aligned instruction handed from the aligner to the queue
interface aligned_ins_if;
	import qupls_fetch_pkg::*;
	logic valid;
	logic ready;
	logic [MAX_INS_BYTES*8-1:0] ins;
	logic [LEN_W-1:0] len;
	logic [31:0] pc;
	modport source (output valid, ins, len, pc, input ready);
	modport sink (input valid, ins, len, pc, output ready);
endinterface

`default_nettype wire

// File: verilog/qupls_line_buffer.sv
// Line buffer collecting fetch-line bytes and releasing them from its head
`timescale 1ns/1ps
`default_nettype none

module qupls_line_buffer (
	input  logic clk,
	input  logic rst,
	input  logic line_valid,
	input  logic [qupls_fetch_pkg::LINE_BYTES*8-1:0] line_data,
	output logic line_ready,
	fetch_buf_if.producer fbuf
);
	import qupls_fetch_pkg::*;

	// Byte store, byte 0 is the head of the stream
	logic [BUF_BYTES-1:0][7:0] bytes_q;
	logic [BUF_BYTES-1:0][7:0] bytes_d;
	logic [LEN_W-1:0] count_q;
	logic [31:0] head_pc_q;

	logic accept;
	logic [LEN_W-1:0] drop;
	logic [LEN_W-1:0] remain;
	logic [BUF_BYTES-1:0][7:0] shifted;
	logic [BUF_BYTES-1:0][7:0] placed;

	// ====================
	// Space and handshake
	// ====================

	// Room for a whole line depends only on the stored count
	// so a take in the same cycle does not affect it
	assign line_ready = count_q <= LEN_W'(BUF_BYTES - LINE_BYTES);
	assign accept = line_valid & line_ready;

	// Bytes the aligner consumes at this edge
	assign drop = fbuf.take ? fbuf.take_len : '0;
	assign remain = count_q - drop;

	// ====================
	// Next byte image
	// ====================

	// Surviving bytes move down to the head
	assign shifted = bytes_q >> {drop, 3'b000};

	// The new line lands right behind the surviving bytes
	assign placed = {{((BUF_BYTES - LINE_BYTES) * 8){1'b0}}, line_data} << {remain, 3'b000};

	always_comb begin
		for (int i = 0; i < BUF_BYTES; i++) begin
			if (i < remain)
				bytes_d[i] = shifted[i];
			else if (accept)
				bytes_d[i] = placed[i];
			else
				bytes_d[i] = 8'h00;
		end
	end

	// Payload store
	always_ff @(posedge clk) begin
		bytes_q <= bytes_d;
	end

	// Count and head address, head address moves with every consumed byte
	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
			head_pc_q <= RESET_PC;
		end else begin
			count_q <= remain + (accept ? LEN_W'(LINE_BYTES) : LEN_W'(0));
			head_pc_q <= head_pc_q + 32'(drop);
		end
	end

	// Present the buffer to the aligner
	assign fbuf.buf_bytes = bytes_q;
	assign fbuf.count = count_q;
	assign fbuf.head_pc = head_pc_q;

endmodule

`default_nettype wire

// File: verilog/qupls_ins_length.sv
// Instruction length decoder mapping an opcode to its size in bytes
`timescale 1ns/1ps
`default_nettype none

module qupls_ins_length (
	input  qupls_fetch_pkg::opcode_t op,
	output logic [qupls_fetch_pkg::LEN_W-1:0] len
);
	import qupls_fetch_pkg::*;

	// Only the 64-bit constant prefixes are long
	// everything else, known or not, is a single five byte word
	always_comb begin
		case (op)
			OP_BSR:    len = LEN_W'(5);
			OP_JSR:    len = LEN_W'(5);
			OP_Bcc:    len = LEN_W'(5);
			OP_BccU:   len = LEN_W'(5);
			OP_CSR:    len = LEN_W'(5);
			OP_FLT3:   len = LEN_W'(5);
			// 32-bit prefixes carry their constant inside one word
			OP_PFXA32: len = LEN_W'(5);
			OP_PFXB32: len = LEN_W'(5);
			OP_PFXC32: len = LEN_W'(5);
			// 64-bit prefixes take a second word for the upper half
			OP_PFXA64: len = LEN_W'(10);
			OP_PFXB64: len = LEN_W'(10);
			OP_PFXC64: len = LEN_W'(10);
			OP_VEC,
			OP_RTS:    len = LEN_W'(5);
			OP_NOP:    len = LEN_W'(5);
			default:   len = LEN_W'(5);
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/qupls_ins_align.sv
// Instruction aligner cutting the head instruction out of the byte stream
`timescale 1ns/1ps
`default_nettype none

module qupls_ins_align (
	fetch_buf_if.consumer fbuf,
	aligned_ins_if.source ins_out
);
	import qupls_fetch_pkg::*;

	opcode_t head_op;
	logic [LEN_W-1:0] head_len;
	logic complete;
	logic [MAX_INS_BYTES*8-1:0] ins_bytes;

	// ====================
	// Length decode
	// ====================

	// The opcode is held in the low bits of the head byte
	assign head_op = opcode_t'(fbuf.buf_bytes[0][6:0]);

	qupls_ins_length u_ins_length (
		.op (head_op),
		.len (head_len)
	);

	// An empty buffer holds a stale head byte, but the count check
	// keeps it from being used since every length is at least five
	assign complete = fbuf.count >= head_len;

	// ====================
	// Extraction
	// ====================

	// Copy the instruction's bytes and clear the unused tail
	always_comb begin
		for (int i = 0; i < MAX_INS_BYTES; i++) begin
			if (i < head_len)
				ins_bytes[i*8 +: 8] = fbuf.buf_bytes[i];
			else
				ins_bytes[i*8 +: 8] = 8'h00;
		end
	end

	assign ins_out.valid = complete;
	assign ins_out.ins = ins_bytes;
	assign ins_out.len = head_len;
	assign ins_out.pc = fbuf.head_pc;

	// ====================
	// Consume
	// ====================

	// The bytes leave the buffer on the same edge as the queue transfer
	assign fbuf.take = complete & ins_out.ready;
	assign fbuf.take_len = head_len;

endmodule

`default_nettype wire

// File: verilog/qupls_ins_queue.sv
// Output queue holding aligned instructions for the downstream decoder
`timescale 1ns/1ps
`default_nettype none

module qupls_ins_queue (
	input  logic clk,
	input  logic rst,
	aligned_ins_if.sink ins_in,
	output logic ins_valid,
	input  logic ins_ready,
	output logic [qupls_fetch_pkg::MAX_INS_BYTES*8-1:0] ins,
	output logic [qupls_fetch_pkg::LEN_W-1:0] ins_len,
	output logic [31:0] ins_pc
);
	import qupls_fetch_pkg::*;

	// Entry storage
	logic [MAX_INS_BYTES*8-1:0] ins_mem [QUEUE_DEPTH];
	logic [LEN_W-1:0] len_mem [QUEUE_DEPTH];
	logic [31:0] pc_mem [QUEUE_DEPTH];

	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] rd_ptr;
	logic [QCNT_W-1:0] occ;
	logic push;
	logic pop;

	// Accept while there is a free slot, a pop in the same cycle is not counted
	assign ins_in.ready = occ != QCNT_W'(QUEUE_DEPTH);
	assign push = ins_in.valid & ins_in.ready;
	assign pop = ins_valid & ins_ready;

	always_ff @(posedge clk) begin
		if (push) begin
			ins_mem[wr_ptr] <= ins_in.ins;
			len_mem[wr_ptr] <= ins_in.len;
			pc_mem[wr_ptr] <= ins_in.pc;
		end
	end

	// Pointers wrap at the queue depth
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occ <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			occ <= occ + QCNT_W'(push) - QCNT_W'(pop);
		end
	end

	// Head entry drives the outputs
	assign ins_valid = occ != '0;
	assign ins = ins_mem[rd_ptr];
	assign ins_len = len_mem[rd_ptr];
	assign ins_pc = pc_mem[rd_ptr];

endmodule

`default_nettype wire

// File: verilog/qupls_fetch_align.sv
// Fetch alignment top turning fetch lines into a stream of whole instructions
`timescale 1ns/1ps
`default_nettype none

module qupls_fetch_align (
	input  logic clk,
	input  logic rst,
	// Fetch line input
	input  logic line_valid,
	input  logic [qupls_fetch_pkg::LINE_BYTES*8-1:0] line_data,
	input  logic [31:0] line_pc,
	output logic line_ready,
	// Aligned instruction output
	output logic ins_valid,
	input  logic ins_ready,
	output logic [qupls_fetch_pkg::MAX_INS_BYTES*8-1:0] ins,
	output logic [qupls_fetch_pkg::LEN_W-1:0] ins_len,
	output logic [31:0] ins_pc
);

	// line_pc is only compared against head_pc plus count by the bound checkers
	// since the buffer derives every address from the reset address

	// Buffer to aligner
	fetch_buf_if fetch_buf ();
	// Aligner to queue
	aligned_ins_if aligned_ins ();

	qupls_line_buffer u_line_buffer (
		.clk (clk),
		.rst (rst),
		.line_valid (line_valid),
		.line_data (line_data),
		.line_ready (line_ready),
		.fbuf (fetch_buf.producer)
	);

	qupls_ins_align u_ins_align (
		.fbuf (fetch_buf.consumer),
		.ins_out (aligned_ins.source)
	);

	qupls_ins_queue u_ins_queue (
		.clk (clk),
		.rst (rst),
		.ins_in (aligned_ins.sink),
		.ins_valid (ins_valid),
		.ins_ready (ins_ready),
		.ins (ins),
		.ins_len (ins_len),
		.ins_pc (ins_pc)
	);

endmodule

`default_nettype wire

// File: testbench/qupls_fetch_align_assertions.sv
// Protocol checkers for the fetch aligner, bound into its top level
`timescale 1ns/1ps
`default_nettype none

module qupls_fetch_align_assertions (
	input logic clk,
	input logic rst,
	input logic line_valid,
	input logic line_ready,
	input logic [31:0] line_pc,
	input logic ins_valid,
	input logic ins_ready,
	input logic [qupls_fetch_pkg::MAX_INS_BYTES*8-1:0] ins,
	input logic [qupls_fetch_pkg::LEN_W-1:0] ins_len,
	input logic [31:0] ins_pc,
	input logic [qupls_fetch_pkg::LEN_W-1:0] count,
	input logic [31:0] head_pc,
	input logic take,
	input logic [qupls_fetch_pkg::LEN_W-1:0] take_len,
	input logic q_push,
	input logic [qupls_fetch_pkg::QCNT_W-1:0] q_occ
);
	import qupls_fetch_pkg::*;

	// Number of failed checks so far
	int fail_count = 0;

	function automatic void flag_failure(string what);
		$error("%s", what);
		fail_count++;
	endfunction

	// The cycle after a reset edge shows an empty buffer and an empty queue
	a_reset_values: assert property (@(posedge clk) rst |=> line_ready && !ins_valid)
		else flag_failure("line_ready or ins_valid not at reset value after reset");

	// Input side stalls only when a whole line no longer fits
	a_ready_space: assert property (@(posedge clk) disable iff (rst)
		!line_ready |-> count > LEN_W'(BUF_BYTES - LINE_BYTES))
		else flag_failure("line_ready low while the buffer still had room for a line");

	// Each accepted line continues the byte stream right behind the buffered bytes
	a_line_address: assert property (@(posedge clk) disable iff (rst)
		line_valid && line_ready |-> line_pc == head_pc + 32'(count))
		else flag_failure("accepted line address does not follow the buffered bytes");

	a_take_fits: assert property (@(posedge clk) disable iff (rst)
		take |-> take_len <= count)
		else flag_failure("aligner consumed more bytes than the buffer held");

	a_queue_room: assert property (@(posedge clk) disable iff (rst)
		q_push |-> q_occ != QCNT_W'(QUEUE_DEPTH))
		else flag_failure("output queue accepted an entry while full");

	// A stalled output keeps its valid and its payload
	a_out_hold: assert property (@(posedge clk) disable iff (rst)
		ins_valid && !ins_ready |=> ins_valid && $stable(ins) && $stable(ins_len)
			&& $stable(ins_pc))
		else flag_failure("output instruction changed or vanished while stalled");

endmodule

`default_nettype wire

// File: testbench/tb_qupls_fetch_align.sv
// Testbench for the fetch aligner driving a random program and checking each instruction
`timescale 1ns/1ps
`default_nettype none

module tb_qupls_fetch_align;
	import qupls_fetch_pkg::*;

	localparam int NUM_INS = 300;
	localparam logic [31:0] SEED = 32'h3444_59d4;
	// About 64 cycles per instruction covers the heaviest stall mix, plus start-up margin
	localparam int TIMEOUT_CYCLES = NUM_INS * 64 + 800;

	logic clk;
	logic rst;
	logic line_valid;
	logic [LINE_BYTES*8-1:0] line_data;
	logic [31:0] line_pc;
	logic line_ready;
	logic ins_valid;
	logic ins_ready;
	logic [MAX_INS_BYTES*8-1:0] ins;
	logic [LEN_W-1:0] ins_len;
	logic [31:0] ins_pc;

	// Expected instructions in program order and the fetch lines holding them
	logic [MAX_INS_BYTES*8-1:0] exp_ins [NUM_INS];
	logic [LEN_W-1:0] exp_len [NUM_INS];
	logic [LINE_BYTES*8-1:0] lines [$];
	logic [31:0] next_pc = RESET_PC;
	int rx_count = 0;
	int cycles = 0;

	qupls_fetch_align u_dut (.*);

	bind qupls_fetch_align qupls_fetch_align_assertions u_assertions (
		.*,
		.count (fetch_buf.count),
		.head_pc (fetch_buf.head_pc),
		.take (fetch_buf.take),
		.take_len (fetch_buf.take_len),
		.q_push (u_ins_queue.push),
		.q_occ (u_ins_queue.occ)
	);

	// Only the three 64-bit constant prefixes are ten bytes long
	function automatic int rule_length(logic [6:0] op);
		if (op == OP_PFXA64 || op == OP_PFXB64 || op == OP_PFXC64)
			return 10;
		return 5;
	endfunction

	task automatic fail_run(string line);
		$display("%s", line);
		$display("=== FAIL ===");
		$fatal(1, "Run stopped at the first failure");
	endtask

	// ====================
	// Program and lines
	// ====================

	task automatic build_program();
		logic [7:0] stream [$];
		logic [6:0] op;
		logic [7:0] b;
		logic [LINE_BYTES*8-1:0] line;
		int len;
		for (int n = 0; n < NUM_INS; n++) begin
			// Roughly one in four is a long prefix
			if ($urandom_range(3) == 0) begin
				case ($urandom_range(2))
					0: op = OP_PFXA64;
					1: op = OP_PFXB64;
					default: op = OP_PFXC64;
				endcase
			end else begin
				do
					op = 7'($urandom);
				while (rule_length(op) == 10);
			end
			len = rule_length(op);
			exp_len[n] = LEN_W'(len);
			exp_ins[n] = '0;
			for (int i = 0; i < len; i++) begin
				b = (i == 0) ? {1'($urandom), op} : 8'($urandom);
				exp_ins[n][i*8 +: 8] = b;
				stream.push_back(b);
			end
		end
		// The tail is filled with NOP bytes up to a whole line
		while (stream.size() % LINE_BYTES != 0)
			stream.push_back({1'b0, OP_NOP});
		for (int l = 0; l < stream.size() / LINE_BYTES; l++) begin
			for (int j = 0; j < LINE_BYTES; j++)
				line[j*8 +: 8] = stream[l*LINE_BYTES + j];
			lines.push_back(line);
		end
	endtask

	task automatic drive_lines();
		for (int l = 0; l < lines.size(); l++) begin
			line_valid = 1'b0;
			repeat ($urandom_range(3) == 0 ? $urandom_range(1, 4) : 0) @(negedge clk);
			line_valid = 1'b1;
			line_data = lines[l];
			line_pc = RESET_PC + 32'(l * LINE_BYTES);
			// line_ready only moves at the rising edge so it is settled here
			while (!line_ready)
				@(negedge clk);
			@(negedge clk);
		end
		line_valid = 1'b0;
	endtask

	task automatic drive_ready();
		forever begin
			@(negedge clk);
			ins_ready = $urandom_range(9) < 7;
		end
	endtask

	// ====================
	// Clock and checks
	// ====================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Every output transfer is compared with the model at its own edge
	always @(posedge clk) begin
		if (!rst && ins_valid && ins_ready && rx_count < NUM_INS) begin
			assert (ins == exp_ins[rx_count])
			else fail_run($sformatf("ERROR at %0t ns: instruction %0d is %h, expected %h",
				$time, rx_count, ins, exp_ins[rx_count]));
			assert (ins_len == exp_len[rx_count])
			else fail_run($sformatf("ERROR at %0t ns: instruction %0d length %0d, expected %0d",
				$time, rx_count, ins_len, exp_len[rx_count]));
			assert (ins_pc == next_pc)
			else fail_run($sformatf("ERROR at %0t ns: instruction %0d address %h, expected %h",
				$time, rx_count, ins_pc, next_pc));
			next_pc = next_pc + 32'(exp_len[rx_count]);
			rx_count++;
		end
	end

	always @(u_dut.u_assertions.fail_count) begin
		if (u_dut.u_assertions.fail_count != 0)
			fail_run("A bound protocol assertion on the DUT failed");
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
			fail_run($sformatf("Run timed out after %0d cycles with %0d of %0d instructions seen",
				cycles, rx_count, NUM_INS));
	end

	initial begin
		rst = 1'b1;
		line_valid = 1'b0;
		line_data = '0;
		line_pc = '0;
		ins_ready = 1'b0;
		void'($urandom(SEED));
		build_program();
		repeat (4) @(negedge clk);
		rst = 1'b0;
		fork
			drive_lines();
			drive_ready();
		join_none
		wait (rx_count == NUM_INS);
		@(negedge clk);
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/qupls_fetch_pkg.sv
verilog/qupls_fetch_if.sv
verilog/qupls_line_buffer.sv
verilog/qupls_ins_length.sv
verilog/qupls_ins_align.sv
verilog/qupls_ins_queue.sv
verilog/qupls_fetch_align.sv
testbench/qupls_fetch_align_assertions.sv
testbench/tb_qupls_fetch_align.sv
